/* hdl/cache_pkg.sv */
package cache_pkg;

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 16;
   localparam int OFFSET_W   = 2;                           // Four words per line
   localparam int INDEX_W    = 4;                           // Must match NUM_SETS at the top
   localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
   localparam int LINE_WORDS = 2 ** OFFSET_W;

   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } addr_fields_t;

   // Flat word or split fields
   typedef union packed {
      logic [ADDR_W-1:0] word;
      addr_fields_t      f;
   } cache_addr_u;

   typedef struct packed {
      cache_addr_u       addr;
      logic [DATA_W-1:0] wdata;
      logic              read;
      logic              write;
   } cpu_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;                              // Word address
      logic [DATA_W-1:0] wdata;
      logic              rd;
      logic              wr;
   } mem_req_t;

   typedef struct packed {
      logic en;
      logic comp;
      logic cache_wr;
      logic fill;
      logic inc;
   } ctrl_cmd_t;

endpackage

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                            clk,
   input  logic                            rst,
   input  cache_pkg::cpu_req_t             req,
   input  logic                            hit,
   input  logic                            dirty,
   input  logic                            valid,
   input  logic                            mem_stall,
   input  logic [cache_pkg::OFFSET_W-1:0]  cnt,
   input  logic                            fill_done,
   output cache_pkg::ctrl_cmd_t            cmd,
   output logic                            mem_rd,
   output logic                            mem_wr,
   output logic                            done,
   output logic                            cache_hit,
   output logic                            stall,
   output logic                            err
);

   typedef enum logic [2:0] {
      IDLE        = 3'd0,
      ACCESS_RD   = 3'd1,
      MEM_WR      = 3'd2,
      MEM_RD_1    = 3'd3,
      MEM_RD_2    = 3'd4,
      ACCESS_WR_2 = 3'd5,
      ACCESS_WR   = 3'd6
   } state_t;

   localparam logic [cache_pkg::OFFSET_W-1:0] LAST_WORD = '1;

   state_t state_q;
   state_t nxt_state;
   logic   req_any;
   logic   hit_ok;
   logic   input_error;
   logic   case_err;

   assign req_any = req.read | req.write;
   assign hit_ok  = hit & valid;

   // Unknown on any input flags an error
   assign input_error = (^{req, hit, dirty, valid, mem_stall, cnt, fill_done} === 1'bx);
   assign err         = input_error | case_err;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= nxt_state;
      end
   end

   always_comb begin
      cmd       = '0;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      done      = 1'b0;
      cache_hit = 1'b0;
      stall     = 1'b1;
      case_err  = 1'b0;
      nxt_state = state_q;

      case (state_q)
         IDLE: begin
            cmd.en       = req_any;
            cmd.comp     = req_any;
            cmd.cache_wr = req.write;                       // Store gates this with hit
            done         = req_any & hit_ok;
            cache_hit    = req_any & hit_ok;
            stall        = req_any & ~hit_ok;
            if (req_any && !hit_ok) begin
               nxt_state = ACCESS_RD;
            end
         end
         ACCESS_RD: begin
            cmd.en    = 1'b1;
            nxt_state = (dirty & valid) ? MEM_WR : MEM_RD_1; // Victim needs write-back?
         end
         MEM_WR: begin
            cmd.en  = 1'b1;
            mem_wr  = 1'b1;
            cmd.inc = ~mem_stall;                           // Hold while bank busy
            if (!mem_stall && cnt == LAST_WORD) begin
               nxt_state = MEM_RD_1;
            end
         end
         MEM_RD_1: begin
            mem_rd   = 1'b1;
            cmd.fill = 1'b1;                                // Early words return while issuing
            cmd.inc  = ~mem_stall;
            if (!mem_stall && cnt == LAST_WORD) begin
               nxt_state = MEM_RD_2;
            end
         end
         MEM_RD_2: begin
            cmd.fill = 1'b1;
            if (fill_done) begin
               nxt_state = ACCESS_WR_2;
            end
         end
         ACCESS_WR_2: begin
            // Line is valid now, so a pending write lands as a hit
            cmd.en       = 1'b1;
            cmd.comp     = 1'b1;
            cmd.cache_wr = req.write;
            nxt_state    = ACCESS_WR;
         end
         ACCESS_WR: begin
            cmd.en    = 1'b1;
            cmd.comp  = 1'b1;
            done      = 1'b1;                               // Replay finishes, hit stays low
            stall     = 1'b0;
            nxt_state = IDLE;
         end
         default: begin
            case_err  = 1'b1;
            nxt_state = IDLE;
         end
      endcase
   end

endmodule

/* hdl/cache_store.sv */
`timescale 1ns/1ps

module cache_store #(
   parameter int NUM_SETS = 16
) (
   input  logic                            clk,
   input  logic                            rst,
   input  cache_pkg::cpu_req_t             req,
   input  cache_pkg::ctrl_cmd_t            cmd,
   input  logic                            mem_rd,
   input  logic                            mem_wr,
   input  logic [cache_pkg::DATA_W-1:0]    mem_rdata,
   input  logic                            mem_rvalid,
   output logic                            hit,
   output logic                            dirty,
   output logic                            valid,
   output logic [cache_pkg::OFFSET_W-1:0]  cnt,
   output logic                            fill_done,
   output logic [cache_pkg::DATA_W-1:0]    rdata,
   output cache_pkg::mem_req_t             mem
);

   logic [cache_pkg::TAG_W-1:0]    tag_q   [NUM_SETS];
   logic [cache_pkg::DATA_W-1:0]   data_q  [NUM_SETS][cache_pkg::LINE_WORDS];
   logic [NUM_SETS-1:0]            valid_q;
   logic [NUM_SETS-1:0]            dirty_q;
   logic [cache_pkg::OFFSET_W-1:0] cnt_q;
   logic [cache_pkg::OFFSET_W-1:0] fill_ptr_q;                // Counts returned words

   logic [cache_pkg::INDEX_W-1:0]  idx;
   logic [cache_pkg::TAG_W-1:0]    req_tag;
   logic                           tag_eq;
   logic                           line_wr;
   logic                           fill_wr;
   cache_pkg::cache_addr_u         wb_addr;
   cache_pkg::cache_addr_u         rf_addr;

   assign idx     = req.addr.f.index;
   assign req_tag = req.addr.f.tag;
   assign tag_eq  = (tag_q[idx] == req_tag);

   assign valid = valid_q[idx];
   assign dirty = valid_q[idx] & dirty_q[idx];
   assign hit   = cmd.en & valid_q[idx] & tag_eq;
   assign rdata = data_q[idx][req.addr.f.offset];
   assign cnt   = cnt_q;

   assign line_wr   = cmd.en & cmd.comp & cmd.cache_wr & hit;
   assign fill_wr   = cmd.fill & mem_rvalid;
   assign fill_done = fill_wr & (fill_ptr_q == '1);

   // Victim address from stored tag, refill address from request tag
   always_comb begin
      wb_addr.f.tag    = tag_q[idx];
      wb_addr.f.index  = idx;
      wb_addr.f.offset = cnt_q;
      rf_addr.f.tag    = req_tag;
      rf_addr.f.index  = idx;
      rf_addr.f.offset = cnt_q;
      mem.addr         = mem_wr ? wb_addr.word : rf_addr.word;
      mem.wdata        = data_q[idx][cnt_q];
      mem.rd           = mem_rd;
      mem.wr           = mem_wr;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q    <= '0;
         dirty_q    <= '0;
         cnt_q      <= '0;
         fill_ptr_q <= '0;
      end else begin
         if (cmd.inc) begin
            cnt_q <= cnt_q + 1'b1;
         end
         if (fill_wr) begin
            fill_ptr_q <= fill_ptr_q + 1'b1;                 // Wraps to zero after the line
         end
         if (line_wr) begin
            dirty_q[idx] <= 1'b1;
         end
         if (fill_done) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (line_wr) begin
         data_q[idx][req.addr.f.offset] <= req.wdata;
      end
      if (fill_wr) begin
         data_q[idx][fill_ptr_q] <= mem_rdata;
      end
      if (fill_done) begin
         tag_q[idx] <= req_tag;
      end
   end

endmodule

/* hdl/banked_mem.sv */
`timescale 1ns/1ps

module banked_mem #(
   parameter int BANK_BUSY   = 3,
   parameter int MEM_LATENCY = 2
) (
   input  logic                          clk,
   input  logic                          rst,
   input  cache_pkg::mem_req_t           req,
   output logic                          stall,
   output logic [cache_pkg::DATA_W-1:0]  rdata,
   output logic                          rvalid
);

   localparam int NUM_BANKS  = 4;
   localparam int BANK_W     = 2;
   localparam int BANK_WORDS = 2 ** (cache_pkg::ADDR_W - BANK_W);
   localparam int BUSY_W     = $clog2(BANK_BUSY + 1);

   logic [cache_pkg::DATA_W-1:0] bank_q  [NUM_BANKS][BANK_WORDS];
   logic [BUSY_W-1:0]            busy_q  [NUM_BANKS];
   logic [MEM_LATENCY-1:0]       rv_q;
   logic [cache_pkg::DATA_W-1:0] rd_q    [MEM_LATENCY];

   logic [BANK_W-1:0]                   bank;
   logic [cache_pkg::ADDR_W-BANK_W-1:0] word;
   logic                                accept;
   logic                                rd_accept;

   assign bank      = req.addr[BANK_W-1:0];                 // Line words spread over banks
   assign word      = req.addr[cache_pkg::ADDR_W-1:BANK_W];
   assign stall     = (req.rd | req.wr) & (busy_q[bank] != '0);
   assign accept    = (req.rd | req.wr) & ~stall;
   assign rd_accept = accept & req.rd;

   assign rvalid = rv_q[MEM_LATENCY-1];
   assign rdata  = rd_q[MEM_LATENCY-1];

   // Each word starts as its own address XOR 16'h5a5a
   initial begin
      logic [cache_pkg::ADDR_W-1:0] a;
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int w = 0; w < BANK_WORDS; w++) begin
            a            = {w[cache_pkg::ADDR_W-BANK_W-1:0], b[BANK_W-1:0]};
            bank_q[b][w] = a ^ 16'h5a5a;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_q[b] <= '0;
         end
         rv_q <= '0;
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && bank == b[BANK_W-1:0]) begin
               busy_q[b] <= BUSY_W'(BANK_BUSY);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - 1'b1;
            end
         end
         rv_q[0] <= rd_accept;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            rv_q[i] <= rv_q[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && req.wr) begin
         bank_q[bank][word] <= req.wdata;
      end
      rd_q[0] <= bank_q[bank][word];                        // Captured at acceptance
      for (int i = 1; i < MEM_LATENCY; i++) begin
         rd_q[i] <= rd_q[i-1];
      end
   end

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
   parameter int NUM_SETS    = 16,
   parameter int BANK_BUSY   = 3,
   parameter int MEM_LATENCY = 2
) (
   input  logic                          clk,
   input  logic                          rst,
   input  cache_pkg::cpu_req_t           req,
   output logic [cache_pkg::DATA_W-1:0]  rdata,
   output logic                          done,
   output logic                          cache_hit,
   output logic                          stall,
   output logic                          err
);

   cache_pkg::ctrl_cmd_t            cmd;
   cache_pkg::mem_req_t             mem_req;
   logic                            hit;
   logic                            dirty;
   logic                            valid;
   logic [cache_pkg::OFFSET_W-1:0]  cnt;
   logic                            fill_done;
   logic                            mem_rd;
   logic                            mem_wr;
   logic                            mem_stall;
   logic [cache_pkg::DATA_W-1:0]    mem_rdata;
   logic                            mem_rvalid;

   cache_ctrl i_cache_ctrl (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .hit       (hit),
      .dirty     (dirty),
      .valid     (valid),
      .mem_stall (mem_stall),
      .cnt       (cnt),
      .fill_done (fill_done),
      .cmd       (cmd),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .err       (err)
   );

   cache_store #(
      .NUM_SETS (NUM_SETS)
   ) i_cache_store (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .cmd        (cmd),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .hit        (hit),
      .dirty      (dirty),
      .valid      (valid),
      .cnt        (cnt),
      .fill_done  (fill_done),
      .rdata      (rdata),
      .mem        (mem_req)
   );

   banked_mem #(
      .BANK_BUSY   (BANK_BUSY),
      .MEM_LATENCY (MEM_LATENCY)
   ) i_banked_mem (
      .clk    (clk),
      .rst    (rst),
      .req    (mem_req),
      .stall  (mem_stall),
      .rdata  (mem_rdata),
      .rvalid (mem_rvalid)
   );

endmodule

/* dv/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

   localparam int NUM_SETS     = 16;
   localparam int NUM_DIRECTED = 10;
   localparam int NUM_RANDOM   = 240;
   localparam int RESET_CYCLES = 8;
   localparam int CLK_HALF     = 50;
   localparam int DRIVE_DLY    = 10;
   localparam int MEM_WORDS    = 2 ** cache_pkg::ADDR_W;

   logic                         clk;
   logic                         rst;
   cache_pkg::cpu_req_t          req;
   logic [cache_pkg::DATA_W-1:0] rdata;
   logic                         done;
   logic                         cache_hit;
   logic                         stall;
   logic                         err;

   logic                         req_any;
   logic                         exp_hit;                  // Line present per tag model
   logic [cache_pkg::DATA_W-1:0] exp_rdata;
   logic [cache_pkg::DATA_W-1:0] model_mem [MEM_WORDS];   // Processor view of memory
   logic [cache_pkg::TAG_W-1:0]  line_tag  [NUM_SETS];
   logic [NUM_SETS-1:0]          line_valid;
   int                           seed;

   cache_top #(
      .NUM_SETS    (NUM_SETS),
      .BANK_BUSY   (12),                                   // Refill and write-back hit busy banks
      .MEM_LATENCY (2)
   ) i_cache_top (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .rdata     (rdata),
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .err       (err)
   );

   assign req_any = req.read | req.write;

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      abort_run();
   endtask

   task automatic idle_cycles(input int n);
      req = '0;
      repeat (n) begin
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   // Called 10 ns after a rising edge, returns at the same point after done
   task automatic issue_request(input logic is_write, input logic [cache_pkg::ADDR_W-1:0] addr,
                                input logic [cache_pkg::DATA_W-1:0] wdata);
      cache_pkg::cache_addr_u a;
      a.word    = addr;
      exp_hit   = line_valid[a.f.index] && (line_tag[a.f.index] == a.f.tag);
      exp_rdata = model_mem[addr];
      req.addr  = a;
      req.wdata = wdata;
      req.read  = ~is_write;
      req.write = is_write;
      @(negedge clk);
      while (!done) begin
         @(negedge clk);
      end
      @(posedge clk);
      #DRIVE_DLY;
      req = '0;
      if (is_write) begin
         model_mem[addr] = wdata;
      end
      line_valid[a.f.index] = 1'b1;                        // Write-allocate on every miss
      line_tag[a.f.index]   = a.f.tag;
   endtask

   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      !req_any |-> !done && !stall && !cache_hit)
      else report_mismatch("done, stall or cache_hit high without a request");

   a_no_err: assert property (@(posedge clk) disable iff (rst) !err)
      else report_mismatch("err raised");

   a_hit_same_cycle: assert property (@(posedge clk) disable iff (rst)
      req_any && exp_hit |-> done && cache_hit && !stall)
      else report_mismatch("expected hit did not complete in the request cycle");

   a_stall_until_done: assert property (@(posedge clk) disable iff (rst)
      req_any && !done |-> stall)
      else report_mismatch("stall low while a request is pending");

   a_done_flags: assert property (@(posedge clk) disable iff (rst)
      done |-> !stall && (cache_hit == exp_hit))
      else report_mismatch("wrong cache_hit or stall at done");

   a_no_early_hit: assert property (@(posedge clk) disable iff (rst)
      !done |-> !cache_hit)
      else report_mismatch("cache_hit high without done");

   a_read_data: assert property (@(posedge clk) disable iff (rst)
      done && req.read |-> rdata == exp_rdata)
      else report_mismatch($sformatf("read 0x%04h returned 0x%04h, expected 0x%04h",
                                     req.addr.word, rdata, exp_rdata));

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   initial begin
      repeat (RESET_CYCLES + 20 + (NUM_DIRECTED + NUM_RANDOM) * 60) @(posedge clk);
      $display("Watchdog timeout: the cache never completed a request in time");
      abort_run();
   end

   initial begin
      cache_pkg::cache_addr_u a;
      logic [31:0]            r;
      rst        = 1'b1;
      req        = '0;
      exp_hit    = 1'b0;
      exp_rdata  = '0;
      line_valid = '0;
      seed       = 32'h3b59;
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_mem[i] = 16'(i) ^ 16'h5a5a;
      end
      for (int s = 0; s < NUM_SETS; s++) begin
         line_tag[s] = '0;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;
      idle_cycles(4);                                      // Quiet outputs after reset

      issue_request(1'b0, 16'h1234, 16'h0000);             // Cold miss
      issue_request(1'b0, 16'h1234, 16'h0000);
      issue_request(1'b0, 16'h1235, 16'h0000);             // Same line
      issue_request(1'b1, 16'h1234, 16'hbeef);             // Write hit
      issue_request(1'b0, 16'h1234, 16'h0000);
      issue_request(1'b0, 16'h1274, 16'h0000);             // Same index, evicts dirty line
      issue_request(1'b0, 16'h1234, 16'h0000);             // Refill from memory
      issue_request(1'b1, 16'h0a58, 16'h1357);             // Write miss
      issue_request(1'b0, 16'h0a58, 16'h0000);
      issue_request(1'b0, 16'h0a5a, 16'h0000);

      // Small pool of tags on two sets so lines keep conflicting
      for (int n = 0; n < NUM_RANDOM; n++) begin
         r          = $random(seed);
         a.word     = '0;
         a.f.tag    = cache_pkg::TAG_W'(r[1:0]);
         a.f.index  = cache_pkg::INDEX_W'(r[2] ? 4 : 9);
         a.f.offset = r[5:4];
         issue_request(r[8], a.word, r[31:16]);
         if (r[9]) begin
            idle_cycles(1);
         end
      end

      idle_cycles(4);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* compile.f */
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_store.sv
hdl/banked_mem.sv
hdl/cache_top.sv
dv/cache_tb.sv

/* Makefile */
SIM      := verilator
VFLAGS   := --binary --timing --assert -j 0
TOP      := cache_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
